// File: hw/io_macros.svh
// ======================================
// IO harness parameters
// Bus widths, queue depth, memory size
// and the IO address map
// ======================================

`ifndef IO_MACROS_SVH
`define IO_MACROS_SVH

// Bus widths
`define IO_ADDR_W 8
`define IO_DATA_W 32

// Queue entries, also the loader credit count
`define IO_FIFO_DEPTH 4

// Word memory covers addresses 0 up to IO_MEM_WORDS-1
`define IO_MEM_WORDS 64

// Host device registers
`define IO_HOST_BASE 8'h80
`define IO_HOST_PUTCHAR_OFS 0
`define IO_HOST_FINISH_OFS 1

`endif

// File: hw/io_pkg.sv
// ======================================
// IO harness types
// Shared vectors, opcodes and the record,
// command and response structs
// ======================================

`default_nettype none

`include "io_macros.svh"

package io_pkg;

  typedef logic [`IO_ADDR_W-1:0] io_addr_t;
  typedef logic [`IO_DATA_W-1:0] io_data_t;

  // Holds 0 up to the full credit count
  typedef logic [$clog2(`IO_FIFO_DEPTH + 1)-1:0] io_credit_t;

  typedef enum logic [1:0]
  {
    e_nbf_write  = 2'b00,
    e_nbf_read   = 2'b01,
    e_nbf_fence  = 2'b10,
    e_nbf_finish = 2'b11
  } nbf_op_e;

  typedef enum logic
  {
    e_mem_write = 1'b0,
    e_mem_read  = 1'b1
  } mem_op_e;

  typedef struct packed
  {
    nbf_op_e  op;
    io_addr_t addr;
    io_data_t data;
  } nbf_rec_s;

  typedef struct packed
  {
    mem_op_e  op;
    io_addr_t addr;
    io_data_t data;
  } mem_cmd_s;

  typedef struct packed
  {
    mem_op_e  op;
    io_addr_t addr;
    io_data_t data;
    logic     err;
  } mem_resp_s;

endpackage

`default_nettype wire

// File: hw/nbf_loader.sv
// ======================================
// Program loader
// Turns load records into memory commands
// under credit flow control, with fence
// and finish handling
// ======================================

`timescale 1ns/1ps
`default_nettype none

`include "io_macros.svh"

module nbf_loader
  (input  logic             clk_i
  ,input  logic             reset_i

  ,input  logic             nbf_v_i
  ,input  io_pkg::nbf_rec_s nbf_i
  ,output logic             nbf_ready_o

  ,output logic             cmd_v_o
  ,output io_pkg::mem_cmd_s cmd_o
  ,input  logic             credit_i

  ,input  logic             resp_v_i
  ,input  logic             resp_ready_i

  ,output logic             loading_o
  );

  import io_pkg::*;

  typedef enum logic [1:0]
  {
    e_run,
    e_fence_wait,
    e_done
  } state_e;

  state_e     state_r, state_n;
  io_credit_t credit_r;
  logic [3:0] out_cnt_r;
  logic       cmd_v_r;
  mem_cmd_s   cmd_r;
  mem_cmd_s   cmd_n;
  logic       nbf_yumi;
  logic       rec_has_cmd;
  logic       resp_done;

  // A command held in the output stage already owns one credit
  assign nbf_ready_o = (state_r == e_run) && (credit_r > io_credit_t'(cmd_v_r));
  assign nbf_yumi    = nbf_v_i && nbf_ready_o;
  assign rec_has_cmd = (nbf_i.op != e_nbf_fence);
  assign resp_done   = resp_v_i && resp_ready_i;

  assign cmd_v_o   = cmd_v_r;
  assign cmd_o     = cmd_r;
  assign loading_o = (state_r != e_done);

  always_comb
  begin
    cmd_n.op   = (nbf_i.op == e_nbf_read) ? e_mem_read : e_mem_write;
    cmd_n.addr = nbf_i.addr;
    cmd_n.data = nbf_i.data;
    // Finish becomes a store of 1 to the host finish register
    if (nbf_i.op == e_nbf_finish)
    begin
      cmd_n.addr = io_addr_t'(`IO_HOST_BASE + `IO_HOST_FINISH_OFS);
      cmd_n.data = io_data_t'(1);
    end
  end

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_run:
      begin
        if (nbf_yumi && (nbf_i.op == e_nbf_fence))
          state_n = e_fence_wait;
        else if (nbf_yumi && (nbf_i.op == e_nbf_finish))
          state_n = e_done;
      end
      e_fence_wait:
      begin
        // Drained once nothing is staged and every sent command has answered
        if (!cmd_v_r && (out_cnt_r == '0))
          state_n = e_run;
      end
      default:
        state_n = state_r;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r   <= e_run;
      credit_r  <= io_credit_t'(`IO_FIFO_DEPTH);
      out_cnt_r <= '0;
      cmd_v_r   <= 1'b0;
    end
    else
    begin
      state_r   <= state_n;
      credit_r  <= credit_r - io_credit_t'(cmd_v_r) + io_credit_t'(credit_i);
      out_cnt_r <= out_cnt_r + 4'(cmd_v_r) - 4'(resp_done);
      cmd_v_r   <= nbf_yumi && rec_has_cmd;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (nbf_yumi && rec_has_cmd)
      cmd_r <= cmd_n;
  end

endmodule

`default_nettype wire

// File: hw/cmd_credit_fifo.sv
// ======================================
// Credit-counted command queue
// Circular buffer that hands back one
// credit per popped entry
// ======================================

`timescale 1ns/1ps
`default_nettype none

`include "io_macros.svh"

module cmd_credit_fifo
  (input  logic             clk_i
  ,input  logic             reset_i

  ,input  logic             push_i
  ,input  io_pkg::mem_cmd_s push_data_i

  ,output logic             head_v_o
  ,output io_pkg::mem_cmd_s head_o
  ,input  logic             pop_i

  ,output logic             credit_o
  );

  import io_pkg::*;

  localparam int ptr_w_lp = $clog2(`IO_FIFO_DEPTH);

  // Extra pointer bit tells full from empty
  logic [ptr_w_lp:0]   wr_ptr_r;
  logic [ptr_w_lp:0]   rd_ptr_r;
  mem_cmd_s            mem_r [`IO_FIFO_DEPTH];
  logic                empty;
  logic                pop_acc;

  assign empty    = (wr_ptr_r == rd_ptr_r);
  assign head_v_o = !empty;
  assign head_o   = mem_r[rd_ptr_r[ptr_w_lp-1:0]];
  assign pop_acc  = pop_i && head_v_o;

  // Sender holds a credit for every push, so a push never meets a full queue
  assign credit_o = pop_acc;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr_r <= wr_ptr_r + (ptr_w_lp + 1)'(1);
      if (pop_acc)
        rd_ptr_r <= rd_ptr_r + (ptr_w_lp + 1)'(1);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push_i)
      mem_r[wr_ptr_r[ptr_w_lp-1:0]] <= push_data_i;
  end

endmodule

`default_nettype wire

// File: hw/mem_io_endpoint.sv
// ======================================
// Memory and IO endpoint
// Decodes commands to word memory, host
// registers or unmapped space and returns
// a registered response
// ======================================

`timescale 1ns/1ps
`default_nettype none

`include "io_macros.svh"

module mem_io_endpoint
  (input  logic              clk_i
  ,input  logic              reset_i

  ,input  logic              cmd_v_i
  ,input  io_pkg::mem_cmd_s  cmd_i
  ,output logic              pop_o

  ,output logic              resp_v_o
  ,output io_pkg::mem_resp_s resp_o
  ,input  logic              resp_ready_i

  ,output logic              putchar_v_o
  ,output logic [7:0]        putchar_o
  ,output logic              finish_o
  );

  import io_pkg::*;

  localparam int mem_aw_lp = $clog2(`IO_MEM_WORDS);

  typedef enum logic
  {
    e_mem_clear,
    e_mem_ready
  } mem_state_e;

  mem_state_e           mem_state_r;
  logic [mem_aw_lp-1:0] clear_addr_r;
  io_data_t             mem_r [`IO_MEM_WORDS];
  logic [mem_aw_lp-1:0] mem_idx;
  io_data_t             resp_data;
  logic                 is_mem, is_putchar, is_finish, is_unmapped, is_write;
  logic                 resp_v_r;
  mem_resp_s            resp_r;
  logic                 putchar_v_r;
  logic [7:0]           putchar_r;
  logic                 finish_r;

  assign mem_idx     = cmd_i.addr[mem_aw_lp-1:0];
  assign is_write    = (cmd_i.op == e_mem_write);
  assign is_mem      = (cmd_i.addr < io_addr_t'(`IO_MEM_WORDS));
  assign is_putchar  = (cmd_i.addr == io_addr_t'(`IO_HOST_BASE + `IO_HOST_PUTCHAR_OFS));
  assign is_finish   = (cmd_i.addr == io_addr_t'(`IO_HOST_BASE + `IO_HOST_FINISH_OFS));
  assign is_unmapped = !is_mem && !is_putchar && !is_finish;

  // Take the head only once memory is cleared and the response slot frees up
  assign pop_o = cmd_v_i && (mem_state_r == e_mem_ready) && (!resp_v_r || resp_ready_i);

  // Host and unmapped reads return zero
  assign resp_data = is_write ? cmd_i.data : (is_mem ? mem_r[mem_idx] : '0);

  assign resp_v_o    = resp_v_r;
  assign resp_o      = resp_r;
  assign putchar_v_o = putchar_v_r;
  assign putchar_o   = putchar_r;
  assign finish_o    = finish_r;

  // Walk the memory once after reset writing zeros
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      mem_state_r  <= e_mem_clear;
      clear_addr_r <= '0;
    end
    else if (mem_state_r == e_mem_clear)
    begin
      clear_addr_r <= clear_addr_r + mem_aw_lp'(1);
      if (clear_addr_r == mem_aw_lp'(`IO_MEM_WORDS - 1))
        mem_state_r <= e_mem_ready;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (mem_state_r == e_mem_clear)
      mem_r[clear_addr_r] <= '0;
    else if (pop_o && is_mem && is_write)
      mem_r[mem_idx] <= cmd_i.data;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      resp_v_r    <= 1'b0;
      putchar_v_r <= 1'b0;
      finish_r    <= 1'b0;
    end
    else
    begin
      if (pop_o)
        resp_v_r <= 1'b1;
      else if (resp_ready_i)
        resp_v_r <= 1'b0;
      putchar_v_r <= pop_o && is_putchar && is_write;
      if (pop_o && is_finish && is_write)
        finish_r <= 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (pop_o)
    begin
      resp_r.op   <= cmd_i.op;
      resp_r.addr <= cmd_i.addr;
      resp_r.data <= resp_data;
      resp_r.err  <= is_unmapped;
    end
    if (pop_o && is_putchar && is_write)
      putchar_r <= cmd_i.data[7:0];
  end

endmodule

`default_nettype wire

// File: hw/io_harness_top.sv
// ======================================
// IO harness top
// Loader, command queue and memory/IO
// endpoint on one clock
// ======================================

`timescale 1ns/1ps
`default_nettype none

module io_harness_top
  (input  logic              clk_i
  ,input  logic              reset_i

  ,input  logic              nbf_v_i
  ,input  io_pkg::nbf_rec_s  nbf_i
  ,output logic              nbf_ready_o

  ,output logic              resp_v_o
  ,output io_pkg::mem_resp_s resp_o
  ,input  logic              resp_ready_i

  ,output logic              putchar_v_o
  ,output logic [7:0]        putchar_o
  ,output logic              finish_o
  ,output logic              loading_o
  );

  import io_pkg::*;

  logic     cmd_v;
  mem_cmd_s cmd;
  logic     credit;
  logic     head_v;
  mem_cmd_s head;
  logic     pop;

  nbf_loader loader
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.nbf_v_i(nbf_v_i)
    ,.nbf_i(nbf_i)
    ,.nbf_ready_o(nbf_ready_o)
    ,.cmd_v_o(cmd_v)
    ,.cmd_o(cmd)
    ,.credit_i(credit)
    ,.resp_v_i(resp_v_o)
    ,.resp_ready_i(resp_ready_i)
    ,.loading_o(loading_o)
    );

  cmd_credit_fifo cmd_fifo
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.push_i(cmd_v)
    ,.push_data_i(cmd)
    ,.head_v_o(head_v)
    ,.head_o(head)
    ,.pop_i(pop)
    ,.credit_o(credit)
    );

  mem_io_endpoint endpoint
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.cmd_v_i(head_v)
    ,.cmd_i(head)
    ,.pop_o(pop)
    ,.resp_v_o(resp_v_o)
    ,.resp_o(resp_o)
    ,.resp_ready_i(resp_ready_i)
    ,.putchar_v_o(putchar_v_o)
    ,.putchar_o(putchar_o)
    ,.finish_o(finish_o)
    );

endmodule

`default_nettype wire

// File: tests/tb_io_harness.sv
// ======================================
// IO harness testbench
// Random load records checked against a
// reference model of memory and host
// ======================================

`timescale 1ns/1ps
`default_nettype none

`include "io_macros.svh"

module tb_io_harness;

  import io_pkg::*;

  localparam int rand_recs_lp    = 300;
  localparam int fence_rounds_lp = 3;
  localparam int round_recs_lp   = 6;
  localparam int total_recs_lp   = 4 + rand_recs_lp + fence_rounds_lp * (round_recs_lp + 1);
  localparam int wait_limit_lp   = 2000;
  localparam io_addr_t mem_top_lp      = io_addr_t'(`IO_MEM_WORDS);
  localparam io_addr_t putchar_addr_lp = io_addr_t'(`IO_HOST_BASE + `IO_HOST_PUTCHAR_OFS);
  localparam io_addr_t finish_addr_lp  = io_addr_t'(`IO_HOST_BASE + `IO_HOST_FINISH_OFS);

  logic      clk_i;
  logic      reset_i;
  logic      nbf_v_i;
  nbf_rec_s  nbf_i;
  logic      nbf_ready_o;
  logic      resp_v_o;
  mem_resp_s resp_o;
  logic      resp_ready_i;
  logic      putchar_v_o;
  logic [7:0] putchar_o;
  logic      finish_o;
  logic      loading_o;

  integer    seed = 32'h55bd_e05b;
  logic      bp_en = 1'b0;
  io_data_t  mem_model [`IO_MEM_WORDS];
  mem_resp_s exp_q [$];
  mem_resp_s got_q [$];
  mem_resp_s mon_exp;
  logic      fence_pending = 1'b0;
  logic [7:0] last_char;
  int acc_cnt = 0;
  int done_cnt = 0;
  int fences_done = 0;
  int putchar_cnt = 0;
  int checks = 0;
  int err_cnt = 0;
  int tests_run = 0;
  int tests_failed = 0;

  io_harness_top uut
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.nbf_v_i(nbf_v_i)
    ,.nbf_i(nbf_i)
    ,.nbf_ready_o(nbf_ready_o)
    ,.resp_v_o(resp_v_o)
    ,.resp_o(resp_o)
    ,.resp_ready_i(resp_ready_i)
    ,.putchar_v_o(putchar_v_o)
    ,.putchar_o(putchar_o)
    ,.finish_o(finish_o)
    ,.loading_o(loading_o)
    );

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic check(input logic ok, input string msg);
    checks++;
    assert (ok)
    else
    begin
      $display("Fail at %0d ns: %s", $time, msg);
      err_cnt++;
    end
  endtask

  function automatic nbf_rec_s make_rec(input nbf_op_e op, input io_addr_t addr,
                                        input io_data_t data);
    nbf_rec_s rec;
    rec.op   = op;
    rec.addr = addr;
    rec.data = data;
    return rec;
  endfunction

  // Response predicted from the address map and the model memory
  function automatic mem_resp_s expected_resp(input nbf_rec_s rec);
    mem_resp_s exp;
    logic      in_mem;
    exp.op   = (rec.op == e_nbf_read) ? e_mem_read : e_mem_write;
    exp.addr = (rec.op == e_nbf_finish) ? finish_addr_lp : rec.addr;
    exp.data = (rec.op == e_nbf_finish) ? io_data_t'(1) : rec.data;
    in_mem   = (exp.addr < mem_top_lp);
    exp.err  = !in_mem && (exp.addr != putchar_addr_lp) && (exp.addr != finish_addr_lp);
    if (exp.op == e_mem_read)
      exp.data = in_mem ? mem_model[int'(exp.addr)] : '0;
    return exp;
  endfunction

  function automatic io_addr_t pick_unmapped();
    io_addr_t a;
    a = io_addr_t'($random(seed));
    while (a < mem_top_lp || a == putchar_addr_lp || a == finish_addr_lp)
      a = io_addr_t'($random(seed));
    return a;
  endfunction

  // Called just after a rising edge, returns just after the edge that took the record
  task automatic send_record(input nbf_rec_s rec);
    int waited;
    waited  = 0;
    nbf_v_i = 1'b1;
    nbf_i   = rec;
    @(negedge clk_i);
    while (!nbf_ready_o && waited < wait_limit_lp)
    begin
      @(negedge clk_i);
      waited++;
    end
    if (!nbf_ready_o)
    begin
      $display("Record at address %h was never accepted by the loader", rec.addr);
      err_cnt++;
    end
    @(posedge clk_i);
    #2;
    nbf_v_i = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < wait_limit_lp)
    begin
      @(posedge clk_i);
      n++;
    end
    if (exp_q.size() != 0)
    begin
      $display("Gave up waiting, %0d responses never arrived", exp_q.size());
      err_cnt++;
    end
    @(posedge clk_i);
    #2;
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt == errs_before)
      $display("Test %s: passed", name);
    else
    begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  // Ready stalls of 1 to 8 cycles, drawn at the falling edge
  initial
  begin
    logic        ready_next;
    int          low_left;
    logic [31:0] r;
    resp_ready_i = 1'b1;
    low_left     = 0;
    forever
    begin
      @(negedge clk_i);
      ready_next = 1'b1;
      if (bp_en && low_left > 0)
      begin
        low_left--;
        ready_next = 1'b0;
      end
      else if (bp_en)
      begin
        r = $random(seed);
        if (r[2:0] == 3'd0)
        begin
          low_left   = int'(r[6:4]);
          ready_next = 1'b0;
        end
      end
      @(posedge clk_i);
      #2;
      resp_ready_i = ready_next;
    end
  end

  // Sampled mid cycle, so each handshake seen here completes at the next rising edge
  always @(negedge clk_i)
  begin
    if (!reset_i)
    begin
      if (fence_pending && nbf_ready_o)
      begin
        check(acc_cnt <= done_cnt, "nbf_ready_o rose while commands were outstanding");
        fence_pending = 1'b0;
        fences_done++;
      end
      if (resp_v_o && resp_ready_i)
      begin
        done_cnt++;
        got_q.push_back(resp_o);
        if (exp_q.size() == 0)
        begin
          $display("A response arrived at %0d ns with no command outstanding", $time);
          err_cnt++;
        end
        else
        begin
          mon_exp = exp_q.pop_front();
          check(resp_o == mon_exp,
                $sformatf("response op %0d addr %h data %h err %b, expected %0d %h %h %b",
                          resp_o.op, resp_o.addr, resp_o.data, resp_o.err,
                          mon_exp.op, mon_exp.addr, mon_exp.data, mon_exp.err));
        end
      end
      if (nbf_v_i && nbf_ready_o)
      begin
        if (nbf_i.op == e_nbf_fence)
          fence_pending = 1'b1;
        else
        begin
          exp_q.push_back(expected_resp(nbf_i));
          acc_cnt++;
          if (nbf_i.op == e_nbf_write && nbf_i.addr < mem_top_lp)
            mem_model[int'(nbf_i.addr)] = nbf_i.data;
        end
      end
      if (putchar_v_o)
      begin
        putchar_cnt++;
        last_char = putchar_o;
      end
    end
  end

  initial
  begin
    repeat (10 + total_recs_lp * 40) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, run stopped", 10 + total_recs_lp * 40);
    $display("Simulation FAILED");
    $finish;
  end

  initial
  begin
    int          errs;
    int          base;
    int          i;
    int          k;
    logic [31:0] r;
    io_data_t    data;
    io_addr_t    addr;
    nbf_op_e     op;
    for (i = 0; i < `IO_MEM_WORDS; i++)
      mem_model[i] = '0;
    reset_i = 1'b1;
    nbf_v_i = 1'b0;
    nbf_i   = '0;
    repeat (10) @(posedge clk_i);
    #2;
    reset_i = 1'b0;

    errs = err_cnt;
    @(negedge clk_i);
    check(nbf_ready_o, "nbf_ready_o low after reset");
    check(!resp_v_o, "resp_v_o high after reset");
    check(!putchar_v_o, "putchar_v_o high after reset");
    check(!finish_o, "finish_o high after reset");
    @(posedge clk_i);
    #2;
    end_test("reset state", errs);

    errs = err_cnt;
    got_q.delete();
    r    = $random(seed);
    addr = {2'b00, r[5:0]};
    data = $random(seed);
    send_record(make_rec(e_nbf_write, addr, data));
    send_record(make_rec(e_nbf_read, addr, '0));
    wait_drain();
    check(got_q.size() == 2, $sformatf("got %0d responses, expected 2", got_q.size()));
    if (got_q.size() == 2)
    begin
      check(got_q[0].op == e_mem_write && got_q[0].data == data, "write response data");
      check(got_q[1].op == e_mem_read && got_q[1].data == data && !got_q[1].err,
            "read response data or error flag");
    end
    end_test("write then read", errs);

    errs  = err_cnt;
    base  = done_cnt;
    bp_en = 1'b1;
    for (i = 0; i < rand_recs_lp; i++)
    begin
      r    = $random(seed);
      op   = r[0] ? e_nbf_read : e_nbf_write;
      addr = (r[3:1] != 3'd0) ? {2'b00, r[9:4]} : pick_unmapped();
      data = $random(seed);
      // Occasional idle cycle on the record input
      if (r[12:10] == 3'd0)
      begin
        @(posedge clk_i);
        #2;
      end
      send_record(make_rec(op, addr, data));
    end
    wait_drain();
    check(done_cnt - base == rand_recs_lp,
          $sformatf("%0d responses for %0d records", done_cnt - base, rand_recs_lp));
    end_test("random traffic", errs);

    errs = err_cnt;
    base = fences_done;
    for (i = 0; i < fence_rounds_lp; i++)
    begin
      for (k = 0; k < round_recs_lp; k++)
      begin
        r = $random(seed);
        send_record(make_rec(r[0] ? e_nbf_read : e_nbf_write, {2'b00, r[6:1]}, r));
      end
      send_record(make_rec(e_nbf_fence, '0, '0));
    end
    wait_drain();
    k = 0;
    while (fence_pending && k < wait_limit_lp)
    begin
      @(posedge clk_i);
      #2;
      k++;
    end
    bp_en = 1'b0;
    check(fences_done - base == fence_rounds_lp,
          $sformatf("%0d fences released, expected %0d", fences_done - base, fence_rounds_lp));
    end_test("fence", errs);

    errs = err_cnt;
    base = putchar_cnt;
    data = $random(seed);
    send_record(make_rec(e_nbf_write, putchar_addr_lp, data));
    wait_drain();
    check(putchar_cnt - base == 1, $sformatf("%0d putchar pulses", putchar_cnt - base));
    check(last_char == data[7:0], $sformatf("putchar_o %h, expected %h", last_char, data[7:0]));
    check(!finish_o, "finish_o high before the finish record");
    send_record(make_rec(e_nbf_finish, '0, '0));
    wait_drain();
    repeat (20)
    begin
      @(negedge clk_i);
      check(finish_o && !nbf_ready_o && !loading_o, "loader not stopped after finish");
    end
    @(posedge clk_i);
    #2;
    end_test("host registers", errs);

    $display("Tests run: %0d, tests failed: %0d, checks: %0d, errors: %0d",
             tests_run, tests_failed, checks, err_cnt);
    if (err_cnt == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hw
hw/io_pkg.sv
hw/nbf_loader.sv
hw/cmd_credit_fifo.sv
hw/mem_io_endpoint.sv
hw/io_harness_top.sv
tests/tb_io_harness.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_io_harness
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
